//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_sms_pad
FILELIST  := sms_pad.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_LOG   := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(SIM_LOG) 2>&1 || true
	@if grep -q "sim failed" $(SIM_LOG); then echo "FAIL, see $(SIM_LOG)"; exit 1; fi
	@grep -q "sim passed" $(SIM_LOG) || { echo "no result in $(SIM_LOG)"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

//--- hdl/paddle_encoder.sv
// TH is synchronised first, so a TH edge reaches the nibble two clocks later; position is sampled
module paddle_encoder import sms_pad_pkg::*; (
	input  logic    clk_sys,
	input  logic    reset,
	input  logic    jp_region,
	input  logic    tick_16k,
	input  logic    th,
	input  paddle_t position,
	output nibble_t nibble,
	output logic    tr
);

	logic          th_r;
	logic          th_q;
	logic          th_rise;
	logic          th_fall;
	paddle_t       held;   // Position latched at the start of a pair
	paddle_phase_t phase;

	// ==================================================
	// TH edge detect
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			th_r <= 1'b1;  // TH idles high
			th_q <= 1'b1;
		end else begin
			th_r <= th;
			th_q <= th_r;
		end
	end

	assign th_fall = th_q & ~th_r;
	assign th_rise = ~th_q & th_r;

	// ==================================================
	// Nibble sequencer
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			phase <= PHASE_LOW;
			held  <= '0;
			tr    <= 1'b1;
		end else if (jp_region) begin
			// HPD-200 free runs on the 16 kHz tick
			if (tick_16k) begin
				if (tr) begin
					held  <= position;
					phase <= PHASE_LOW;
					tr    <= 1'b0;
				end else begin
					phase <= PHASE_HIGH;
					tr    <= 1'b1;
				end
			end
		end else begin
			// Export mode, console strobes TH
			if (th_fall) begin
				held  <= position;
				phase <= PHASE_LOW;
				tr    <= 1'b0;
			end else if (th_rise) begin
				phase <= PHASE_HIGH;
				tr    <= 1'b0;
			end
		end
	end

	assign nibble = (phase == PHASE_HIGH) ? held[7:4] : held[3:0];

	// Export paddles never raise TR after a strobe
	a_export_tr_low: assert property (@(posedge clk_sys) disable iff (reset)
		(!jp_region && (th_fall || th_rise)) |=> !tr);

endmodule

//--- hdl/sms_pad_pkg.sv
// Shared widths, timing constants and port types; the constants assume clk_sys near 53.7 MHz
package sms_pad_pkg;

	// ==================================================
	// Widths with a meaning
	// ==================================================
	typedef logic [6:0]  pad_bits_t;    // Host pad, active high: R L D U F1 F2 pause
	typedef logic [7:0]  paddle_t;      // Paddle position
	typedef logic [3:0]  nibble_t;      // Half a paddle position
	typedef logic [1:0]  tap_index_t;   // Multitap pad number
	typedef logic [4:0]  divider_t;     // Phase of the 30 step divider
	typedef logic [11:0] tick_count_t;  // 16 kHz tick counter

	// ==================================================
	// Console side
	// ==================================================
	// One controller port, every line active low
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic tl;
		logic tr;
		logic th;
		logic pause_n;
	} pad_port_t;

	// Clock enable pulses, one clk_sys wide
	typedef struct packed {
		logic ce_cpu;
		logic ce_vdp;
		logic ce_pix;
		logic ce_sp;
	} ce_bus_t;

	// Which paddle nibble is on the port
	typedef enum logic {
		PHASE_LOW,
		PHASE_HIGH
	} paddle_phase_t;

	localparam int DIV_STEPS       = 30;
	localparam int TICK_16K_PERIOD = 3356;   // clk_sys / 16 kHz
	localparam int TAP_TIMEOUT     = 57000;  // ce_cpu ticks of TH high
	localparam int NUM_PORTS       = 2;

	localparam pad_port_t PORT_IDLE = '{default: 1'b1};  // Nothing pressed

endpackage

//--- hdl/sms_pad_top.sv
// Option levels are used as given; synchronise them to clk_sys before this block
module sms_pad_top import sms_pad_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  pad_bits_t joy_0,
	input  pad_bits_t joy_1,
	input  pad_bits_t joy_2,
	input  pad_bits_t joy_3,
	input  logic      swap,
	input  logic      multitap_en,
	input  logic      paddle_en,
	input  logic      jp_region,
	input  paddle_t   paddle_0,
	input  paddle_t   paddle_1,
	input  logic      th_out_a,
	input  logic      th_out_b,
	output pad_port_t port_a,
	output pad_port_t port_b,
	output ce_bus_t   ce
);

	logic                            tick_16k;
	paddle_t [NUM_PORTS-1:0]         paddle_in;
	logic    [NUM_PORTS-1:0]         th_in;
	nibble_t [NUM_PORTS-1:0]         nibble;
	logic    [NUM_PORTS-1:0]         tr;

	assign paddle_in = {paddle_1, paddle_0};
	assign th_in     = {th_out_b, th_out_a};

	sms_timebase u_timebase (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.ce       (ce),
		.tick_16k (tick_16k)
	);

	// One encoder per console port
	for (genvar i = 0; i < NUM_PORTS; i++) begin : g_paddle
		paddle_encoder u_paddle (
			.clk_sys   (clk_sys),
			.reset     (reset),
			.jp_region (jp_region),
			.tick_16k  (tick_16k),
			.th        (th_in[i]),
			.position  (paddle_in[i]),
			.nibble    (nibble[i]),
			.tr        (tr[i])
		);
	end

	sms_port_mux u_port_mux (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ce_cpu      (ce.ce_cpu),
		.swap        (swap),
		.multitap_en (multitap_en),
		.paddle_en   (paddle_en),
		.joy_0       (joy_0),
		.joy_1       (joy_1),
		.joy_2       (joy_2),
		.joy_3       (joy_3),
		.th_out_a    (th_out_a),
		.nibble_a    (nibble[0]),
		.nibble_b    (nibble[1]),
		.tr_a        (tr[0]),
		.tr_b        (tr[1]),
		.port_a      (port_a),
		.port_b      (port_b)
	);

endmodule

//--- hdl/sms_port_mux.sv
// Multitap only on port A; ports are registered, one clock behind joystick and paddle inputs
module sms_port_mux import sms_pad_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      ce_cpu,
	input  logic      swap,
	input  logic      multitap_en,
	input  logic      paddle_en,
	input  pad_bits_t joy_0,
	input  pad_bits_t joy_1,
	input  pad_bits_t joy_2,
	input  pad_bits_t joy_3,
	input  logic      th_out_a,
	input  nibble_t   nibble_a,
	input  nibble_t   nibble_b,
	input  logic      tr_a,
	input  logic      tr_b,
	output pad_port_t port_a,
	output pad_port_t port_b
);

	pad_bits_t  pads [4];
	tap_index_t tap_index;
	logic       th_a_q;
	logic       th_a_fall;
	logic       pause_all;
	pad_port_t  next_a;
	pad_port_t  next_b;
	logic [$clog2(TAP_TIMEOUT + 2) - 1:0] th_high_count;  // Saturates past the timeout

	// Host pad word to console lines
	function automatic pad_port_t to_port(input pad_bits_t p);
		pad_port_t r;
		r.right   = ~p[0];
		r.left    = ~p[1];
		r.down    = ~p[2];
		r.up      = ~p[3];
		r.tl      = ~p[4];
		r.tr      = ~p[5];
		r.th      = 1'b1;
		r.pause_n = ~p[6];
		return r;
	endfunction

	always_comb begin
		pads[0] = swap ? joy_1 : joy_0;
		pads[1] = swap ? joy_0 : joy_1;
		pads[2] = joy_2;
		pads[3] = joy_3;
	end

	// ==================================================
	// Multitap scan
	// ==================================================
	assign th_a_fall = th_a_q & ~th_out_a;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			th_a_q        <= 1'b1;
			tap_index     <= '0;
			th_high_count <= '0;
		end else begin
			th_a_q <= th_out_a;
			if (!multitap_en) begin
				tap_index     <= '0;
				th_high_count <= '0;
			end else if (th_a_fall) begin
				th_high_count <= '0;
				// A strobe after a long high period starts over at pad 0
				if (th_high_count < TAP_TIMEOUT)
					tap_index <= tap_index + 1'b1;
				else
					tap_index <= '0;
			end else if (th_high_count > TAP_TIMEOUT) begin
				tap_index <= '0;
			end else if (ce_cpu && th_out_a) begin
				th_high_count <= th_high_count + 1'b1;
			end
		end
	end

	// ==================================================
	// Port build
	// ==================================================
	always_comb begin
		next_a = to_port(multitap_en ? pads[tap_index] : pads[0]);
		next_b = multitap_en ? PORT_IDLE : to_port(pads[1]);

		pause_all      = next_a.pause_n | next_b.pause_n;  // Both pads must press
		next_a.pause_n = pause_all;
		next_b.pause_n = pause_all;

		if (paddle_en) begin
			{next_a.right, next_a.left, next_a.down, next_a.up} = nibble_a;
			{next_b.right, next_b.left, next_b.down, next_b.up} = nibble_b;
			next_a.tr = tr_a;
			next_b.tr = tr_b;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			port_a <= PORT_IDLE;
			port_b <= PORT_IDLE;
		end else begin
			port_a <= next_a;
			port_b <= next_b;
		end
	end

	a_tap_idle: assert property (@(posedge clk_sys) disable iff (reset)
		!multitap_en |=> (tap_index == '0));

endmodule

//--- hdl/sms_timebase.sv
// Enables are registered, so each pulse lands one clock after its divider phase
module sms_timebase import sms_pad_pkg::*; (
	input  logic    clk_sys,
	input  logic    reset,
	output ce_bus_t ce,
	output logic    tick_16k
);

	divider_t    phase;
	tick_count_t tick_count;
	ce_bus_t     ce_next;

	// ==================================================
	// Phase decode
	// ==================================================
	always_comb begin
		ce_next        = '0;
		ce_next.ce_sp  = phase[0];  // Every other cycle
		case (phase)
			5'd4, 5'd14: ce_next.ce_vdp = 1'b1;
			5'd9, 5'd24: begin
				ce_next.ce_vdp = 1'b1;
				ce_next.ce_cpu = 1'b1;  // Divide by 15
				ce_next.ce_pix = (phase == 5'd9);
			end
			5'd19, 5'd29: begin
				ce_next.ce_vdp = 1'b1;
				ce_next.ce_pix = 1'b1;  // Divide by 10
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			phase      <= '0;
			ce         <= '0;
			tick_count <= '0;
			tick_16k   <= 1'b0;
		end else begin
			ce         <= ce_next;
			phase      <= (phase == divider_t'(DIV_STEPS - 1)) ? '0 : phase + 1'b1;
			tick_16k   <= (tick_count == tick_count_t'(TICK_16K_PERIOD - 1));
			if (tick_count == tick_count_t'(TICK_16K_PERIOD - 1))
				tick_count <= '0;
			else
				tick_count <= tick_count + 1'b1;
		end
	end

	// CPU and pixel enables are subsets of the VDP rate
	a_cpu_on_vdp: assert property (@(posedge clk_sys) disable iff (reset) ce.ce_cpu |-> ce.ce_vdp);
	a_pix_on_vdp: assert property (@(posedge clk_sys) disable iff (reset) ce.ce_pix |-> ce.ce_vdp);

endmodule

//--- sms_pad.f
hdl/sms_pad_pkg.sv
hdl/sms_timebase.sv
hdl/paddle_encoder.sv
hdl/sms_port_mux.sv
hdl/sms_pad_top.sv
test/tb_sms_pad.sv

//--- test/tb_sms_pad.sv
// Directed checks of sms_pad_top; the multitap timeout case alone runs for about 855k clocks
module tb_sms_pad import sms_pad_pkg::*; ();

	localparam int          CLK_PERIOD      = 8;
	localparam int          CPU_CE_SPACING  = 15;  // clk_sys per ce_cpu pulse
	localparam int          WATCHDOG_CYCLES = TAP_TIMEOUT * CPU_CE_SPACING
		+ 12 * TICK_16K_PERIOD + 4000;
	localparam logic [31:0] SEED            = 32'hfa0a_1876;

	logic      clk_sys;
	logic      reset;
	pad_bits_t joy_0;
	pad_bits_t joy_1;
	pad_bits_t joy_2;
	pad_bits_t joy_3;
	logic      swap;
	logic      multitap_en;
	logic      paddle_en;
	logic      jp_region;
	paddle_t   paddle_0;
	paddle_t   paddle_1;
	logic      th_out_a;
	logic      th_out_b;
	pad_port_t port_a;
	pad_port_t port_b;
	ce_bus_t   ce;
	pad_port_t paddle_a_shown;  // What each port shows between strobes
	pad_port_t paddle_b_shown;

	sms_pad_top dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("watchdog expired after %0d clocks, a test is stuck", WATCHDOG_CYCLES);
		stop_with_failure();
	end

	// ==================================================
	// Checks and expected values
	// ==================================================
	task automatic stop_with_failure();
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_port(input string name, input pad_port_t got, input pad_port_t exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_ce(input ce_bus_t got, input ce_bus_t exp);
		if (got !== exp) begin
			$display("mismatch ce: got %h, expected %h", got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_period(input tick_count_t got, input tick_count_t exp);
		if (got !== exp) begin
			$display("mismatch tick_16k period: got %h, expected %h", got, exp);
			stop_with_failure();
		end
	endtask

	function automatic ce_bus_t ce_for_phase(input int p);
		ce_bus_t e;
		e.ce_vdp = (p % 5 == 4);
		e.ce_pix = (p % 10 == 9);
		e.ce_cpu = (p % 15 == 9);
		e.ce_sp  = (p % 2 == 1);
		return e;
	endfunction

	function automatic pad_port_t joy_port(input pad_bits_t p, input logic both_pause);
		return '{up: !p[3], down: !p[2], left: !p[1], right: !p[0], tl: !p[4], tr: !p[5],
			th: 1'b1, pause_n: !both_pause};
	endfunction

	function automatic pad_port_t paddle_port(input nibble_t n, input logic tr_flag);
		pad_port_t e;
		e       = PORT_IDLE;  // Joysticks released during paddle tests
		e.right = n[3];
		e.left  = n[2];
		e.down  = n[1];
		e.up    = n[0];
		e.tr    = tr_flag;
		return e;
	endfunction

	// Returns on the falling edge where the tick is visible
	task automatic wait_for_tick();
		int n;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
		end while (!dut.u_timebase.tick_16k && n < TICK_16K_PERIOD + 4);
		if (!dut.u_timebase.tick_16k) begin
			$display("tick_16k did not pulse within %0d clocks", n);
			stop_with_failure();
		end
	endtask

	// ==================================================
	// Tests
	// ==================================================
	task automatic test_timebase();
		int n;
		check_ce(ce, '0);  // Still the reset value
		for (int p = 0; p < 3 * DIV_STEPS; p++) begin
			@(negedge clk_sys);
			check_ce(ce, ce_for_phase(p % DIV_STEPS));
		end
		wait_for_tick();
		repeat (2) begin
			n = 0;
			do begin
				@(negedge clk_sys);
				n++;
			end while (!dut.u_timebase.tick_16k && n < TICK_16K_PERIOD + 4);
			check_period(tick_count_t'(n), tick_count_t'(TICK_16K_PERIOD));
		end
	endtask

	task automatic test_joystick();
		pad_bits_t first;
		pad_bits_t second;
		for (int i = 0; i < 16; i++) begin
			first     = pad_bits_t'($urandom);
			second    = pad_bits_t'($urandom);
			first[6]  = i[0];  // Walk all pause combinations
			second[6] = i[1];
			joy_0     = first;
			joy_1     = second;
			swap      = i[2];
			@(negedge clk_sys);
			check_port("port_a", port_a, joy_port(i[2] ? second : first, i[0] & i[1]));
			check_port("port_b", port_b, joy_port(i[2] ? first : second, i[0] & i[1]));
		end
		swap = 1'b0;
	endtask

	task automatic test_paddle_jp();
		paddle_t pos_a;
		paddle_t pos_b;
		wait_for_tick();
		@(negedge clk_sys);  // Next tick a full period away
		joy_0     = '0;
		joy_1     = '0;
		paddle_en = 1'b1;
		jp_region = 1'b1;
		pos_a     = paddle_t'($urandom);
		pos_b     = paddle_t'($urandom);
		paddle_0  = pos_a;
		paddle_1  = pos_b;
		@(negedge clk_sys);
		check_port("port_a", port_a, paddle_port(4'h0, 1'b1));
		check_port("port_b", port_b, paddle_port(4'h0, 1'b1));
		repeat (2) begin
			wait_for_tick();
			repeat (2) @(negedge clk_sys);
			check_port("port_a", port_a, paddle_port(pos_a[3:0], 1'b0));
			check_port("port_b", port_b, paddle_port(pos_b[3:0], 1'b0));
			paddle_0 = paddle_t'($urandom);  // Latched value must survive this
			paddle_1 = paddle_t'($urandom);
			wait_for_tick();
			repeat (2) @(negedge clk_sys);
			paddle_a_shown = paddle_port(pos_a[7:4], 1'b1);
			paddle_b_shown = paddle_port(pos_b[7:4], 1'b1);
			check_port("port_a", port_a, paddle_a_shown);
			check_port("port_b", port_b, paddle_b_shown);
			pos_a = paddle_0;
			pos_b = paddle_1;
		end
	endtask

	task automatic test_paddle_export();
		paddle_t pos;
		jp_region = 1'b0;
		repeat (2) begin
			pos      = paddle_t'($urandom);
			paddle_0 = pos;
			th_out_a = 1'b0;
			repeat (4) @(negedge clk_sys);
			check_port("port_a", port_a, paddle_port(pos[3:0], 1'b0));
			check_port("port_b", port_b, paddle_b_shown);
			paddle_0 = paddle_t'($urandom);
			th_out_a = 1'b1;
			repeat (4) @(negedge clk_sys);
			paddle_a_shown = paddle_port(pos[7:4], 1'b0);
			check_port("port_a", port_a, paddle_a_shown);
			check_port("port_b", port_b, paddle_b_shown);
			// Same on port B while port A holds
			pos      = paddle_t'($urandom);
			paddle_1 = pos;
			th_out_b = 1'b0;
			repeat (4) @(negedge clk_sys);
			check_port("port_b", port_b, paddle_port(pos[3:0], 1'b0));
			check_port("port_a", port_a, paddle_a_shown);
			paddle_1 = paddle_t'($urandom);
			th_out_b = 1'b1;
			repeat (4) @(negedge clk_sys);
			paddle_b_shown = paddle_port(pos[7:4], 1'b0);
			check_port("port_b", port_b, paddle_b_shown);
			check_port("port_a", port_a, paddle_a_shown);
		end
	endtask

	task automatic test_multitap();
		pad_bits_t pads [4];
		paddle_en = 1'b0;
		for (int i = 0; i < 4; i++) begin
			pads[i] = pad_bits_t'($urandom) & 7'h3f;  // No pause
		end
		joy_0       = pads[0];
		joy_1       = pads[1];
		joy_2       = pads[2];
		joy_3       = pads[3];
		multitap_en = 1'b1;
		@(negedge clk_sys);
		check_port("port_a", port_a, joy_port(pads[0], 1'b0));
		check_port("port_b", port_b, PORT_IDLE);
		for (int k = 1; k <= 5; k++) begin
			th_out_a = 1'b0;
			repeat (3) @(negedge clk_sys);
			check_port("port_a", port_a, joy_port(pads[k % 4], 1'b0));
			check_port("port_b", port_b, PORT_IDLE);
			th_out_a = 1'b1;
			repeat (2) @(negedge clk_sys);
		end
		// Long TH high keeps pad 1 until the timeout passes
		repeat ((TAP_TIMEOUT - 2) * CPU_CE_SPACING) @(negedge clk_sys);
		check_port("port_a", port_a, joy_port(pads[1], 1'b0));
		repeat (5 * CPU_CE_SPACING + 4) @(negedge clk_sys);
		check_port("port_a", port_a, joy_port(pads[0], 1'b0));
		check_port("port_b", port_b, PORT_IDLE);
		multitap_en = 1'b0;
	endtask

	initial begin
		void'($urandom(SEED));
		reset       = 1'b1;
		joy_0       = '0;
		joy_1       = '0;
		joy_2       = '0;
		joy_3       = '0;
		swap        = 1'b0;
		multitap_en = 1'b0;
		paddle_en   = 1'b0;
		jp_region   = 1'b0;
		paddle_0    = '0;
		paddle_1    = '0;
		th_out_a    = 1'b1;  // TH idles high
		th_out_b    = 1'b1;
		repeat (4) @(negedge clk_sys);
		reset = 1'b0;
		test_timebase();
		test_joystick();
		test_paddle_jp();
		test_paddle_export();
		test_multitap();
		$display("sim passed");
		$finish;
	end

endmodule
